// File: rtl/pic_alu_defines.svh
`ifndef PIC_ALU_DEFINES_SVH
`define PIC_ALU_DEFINES_SVH

`define PIC_DATA_W   8
`define PIC_INSTR_W  14
`define PIC_OP_W     5
`define PIC_BSEL_W   3
`define PIC_STATUS_W 3

`define PIC_D_BIT    7      // Destination select, 1 means F
`define PIC_B_LSB    7      // Bit select is bits 9..7
`define PIC_OPC_LSB  7      // Patterns below cover bits 13..7

// Bit 7 only matters where d picks the instruction
`define PIC_OPC_NOP    7'b0000000
`define PIC_OPC_MOVWF  7'b0000001
`define PIC_OPC_CLRW   7'b0000010
`define PIC_OPC_CLRF   7'b0000011
`define PIC_OPC_SUBWF  7'b000010?
`define PIC_OPC_DECF   7'b000011?
`define PIC_OPC_IORWF  7'b000100?
`define PIC_OPC_ANDWF  7'b000101?
`define PIC_OPC_XORWF  7'b000110?
`define PIC_OPC_ADDWF  7'b000111?
`define PIC_OPC_MOVF   7'b001000?
`define PIC_OPC_COMF   7'b001001?
`define PIC_OPC_INCF   7'b001010?
`define PIC_OPC_DECFSZ 7'b001011?
`define PIC_OPC_RRF    7'b001100?
`define PIC_OPC_RLF    7'b001101?
`define PIC_OPC_SWAPF  7'b001110?
`define PIC_OPC_INCFSZ 7'b001111?
`define PIC_OPC_BCF    7'b0100???
`define PIC_OPC_BSF    7'b0101???
`define PIC_OPC_BTFSC  7'b0110???
`define PIC_OPC_BTFSS  7'b0111???
`define PIC_OPC_MOVLW  7'b1100???
`define PIC_OPC_IORLW  7'b111000?
`define PIC_OPC_ANDLW  7'b111001?
`define PIC_OPC_XORLW  7'b111010?
`define PIC_OPC_SUBLW  7'b11110??
`define PIC_OPC_ADDLW  7'b11111??

`define PIC_OP_NOP    5'd0
`define PIC_OP_ADDWF  5'd1
`define PIC_OP_ANDWF  5'd2
`define PIC_OP_CLRF   5'd3
`define PIC_OP_CLRW   5'd4
`define PIC_OP_COMF   5'd5
`define PIC_OP_DECF   5'd6
`define PIC_OP_INCF   5'd7
`define PIC_OP_IORWF  5'd8
`define PIC_OP_MOVF   5'd9
`define PIC_OP_MOVWF  5'd10
`define PIC_OP_RLF    5'd11
`define PIC_OP_RRF    5'd12
`define PIC_OP_SUBWF  5'd13
`define PIC_OP_SWAPF  5'd14
`define PIC_OP_XORWF  5'd15
`define PIC_OP_INCFSZ 5'd16
`define PIC_OP_DECFSZ 5'd17
`define PIC_OP_BCF    5'd18
`define PIC_OP_BSF    5'd19
`define PIC_OP_BTFSC  5'd20
`define PIC_OP_BTFSS  5'd21
`define PIC_OP_ADDLW  5'd22
`define PIC_OP_ANDLW  5'd23
`define PIC_OP_IORLW  5'd24
`define PIC_OP_MOVLW  5'd25
`define PIC_OP_SUBLW  5'd26
`define PIC_OP_XORLW  5'd27

`define STATUS_C  0
`define STATUS_DC 1
`define STATUS_Z  2

`endif

// File: rtl/pic_alu_pkg.sv
`default_nettype none

`include "pic_alu_defines.svh"

package pic_alu_pkg;

    typedef logic [`PIC_DATA_W-1:0]   data_t;
    typedef logic [`PIC_INSTR_W-1:0]  instr_t;
    typedef logic [`PIC_OP_W-1:0]     alu_op_t;
    typedef logic [`PIC_BSEL_W-1:0]   bit_sel_t;
    typedef logic [`PIC_STATUS_W-1:0] status_t;   // {Z, DC, C}

    typedef struct packed {
        alu_op_t  op;
        logic     dest_f;
        bit_sel_t bit_sel;
        data_t    literal;
    } decoded_t;

    // One record per executed instruction
    typedef struct packed {
        data_t   w;
        data_t   f;
        status_t status;
        logic    skip;
    } alu_result_t;

endpackage

`default_nettype wire

// File: rtl/instr_decoder.sv
`default_nettype none

`include "pic_alu_defines.svh"

module instr_decoder (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire pic_alu_pkg::instr_t    in_data,
    output logic                        dec_valid,
    input  wire                         dec_ready,
    output pic_alu_pkg::decoded_t       dec_data
);

    pic_alu_pkg::decoded_t dec_next;
    logic                  rst_done;
    logic                  in_fire;

    assign in_ready = rst_done && (!dec_valid || dec_ready);   // Empty or draining
    assign in_fire  = in_valid && in_ready;

    always_comb begin
        dec_next.dest_f  = in_data[`PIC_D_BIT];
        dec_next.bit_sel = in_data[`PIC_B_LSB +: `PIC_BSEL_W];
        dec_next.literal = in_data[`PIC_DATA_W-1:0];
        casez (in_data[`PIC_INSTR_W-1:`PIC_OPC_LSB])
            `PIC_OPC_NOP:    dec_next.op = `PIC_OP_NOP;
            `PIC_OPC_MOVWF:  dec_next.op = `PIC_OP_MOVWF;
            `PIC_OPC_CLRW:   dec_next.op = `PIC_OP_CLRW;
            `PIC_OPC_CLRF:   dec_next.op = `PIC_OP_CLRF;
            `PIC_OPC_SUBWF:  dec_next.op = `PIC_OP_SUBWF;
            `PIC_OPC_DECF:   dec_next.op = `PIC_OP_DECF;
            `PIC_OPC_IORWF:  dec_next.op = `PIC_OP_IORWF;
            `PIC_OPC_ANDWF:  dec_next.op = `PIC_OP_ANDWF;
            `PIC_OPC_XORWF:  dec_next.op = `PIC_OP_XORWF;
            `PIC_OPC_ADDWF:  dec_next.op = `PIC_OP_ADDWF;
            `PIC_OPC_MOVF:   dec_next.op = `PIC_OP_MOVF;
            `PIC_OPC_COMF:   dec_next.op = `PIC_OP_COMF;
            `PIC_OPC_INCF:   dec_next.op = `PIC_OP_INCF;
            `PIC_OPC_DECFSZ: dec_next.op = `PIC_OP_DECFSZ;
            `PIC_OPC_RRF:    dec_next.op = `PIC_OP_RRF;
            `PIC_OPC_RLF:    dec_next.op = `PIC_OP_RLF;
            `PIC_OPC_SWAPF:  dec_next.op = `PIC_OP_SWAPF;
            `PIC_OPC_INCFSZ: dec_next.op = `PIC_OP_INCFSZ;
            `PIC_OPC_BCF:    dec_next.op = `PIC_OP_BCF;
            `PIC_OPC_BSF:    dec_next.op = `PIC_OP_BSF;
            `PIC_OPC_BTFSC:  dec_next.op = `PIC_OP_BTFSC;
            `PIC_OPC_BTFSS:  dec_next.op = `PIC_OP_BTFSS;
            `PIC_OPC_MOVLW:  dec_next.op = `PIC_OP_MOVLW;
            `PIC_OPC_IORLW:  dec_next.op = `PIC_OP_IORLW;
            `PIC_OPC_ANDLW:  dec_next.op = `PIC_OP_ANDLW;
            `PIC_OPC_XORLW:  dec_next.op = `PIC_OP_XORLW;
            `PIC_OPC_SUBLW:  dec_next.op = `PIC_OP_SUBLW;
            `PIC_OPC_ADDLW:  dec_next.op = `PIC_OP_ADDLW;
            default:         dec_next.op = `PIC_OP_NOP;     // Unknown word
        endcase
    end

    // Holds in_ready low until the first edge out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_done <= 1'b0;
        end else begin
            rst_done <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (in_fire) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            dec_data <= dec_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_datapath.sv
`default_nettype none

`include "pic_alu_defines.svh"

module alu_datapath (
    input  wire pic_alu_pkg::decoded_t  op_in,
    input  wire pic_alu_pkg::data_t     w,
    input  wire pic_alu_pkg::data_t     f,
    input  wire pic_alu_pkg::status_t   status,
    output pic_alu_pkg::data_t          result,
    output logic                        write_w,
    output logic                        write_f,
    output pic_alu_pkg::status_t        status_next,
    output logic                        skip
);

    localparam int NIB_W = `PIC_DATA_W / 2;
    localparam pic_alu_pkg::data_t ONE = 1;

    pic_alu_pkg::data_t    opnd;
    pic_alu_pkg::data_t    addend;
    pic_alu_pkg::data_t    bit_mask;
    logic [`PIC_DATA_W:0]  sum;
    logic [NIB_W:0]        nib_sum;
    logic                  lit_op;
    logic                  is_sub;
    logic                  sel_bit;

    assign lit_op = (op_in.op >= `PIC_OP_ADDLW) && (op_in.op <= `PIC_OP_XORLW);
    assign is_sub = (op_in.op == `PIC_OP_SUBWF) || (op_in.op == `PIC_OP_SUBLW);
    assign opnd   = lit_op ? op_in.literal : f;

    // Subtract is opnd + ~w + 1, so carry out means no borrow
    assign addend  = is_sub ? ~w : w;
    assign sum     = {1'b0, opnd} + {1'b0, addend} + {{`PIC_DATA_W{1'b0}}, is_sub};
    assign nib_sum = {1'b0, opnd[NIB_W-1:0]} + {1'b0, addend[NIB_W-1:0]}
                   + {{NIB_W{1'b0}}, is_sub};

    assign bit_mask = ONE << op_in.bit_sel;
    assign sel_bit  = f[op_in.bit_sel];

    always_comb begin
        logic byte_dest;
        logic to_w;
        logic to_f;
        logic aff_c;
        logic aff_dc;
        logic aff_z;
        logic c_new;
        logic test_zero;
        logic res_zero;

        result    = f;
        byte_dest = 1'b0;
        to_w      = 1'b0;
        to_f      = 1'b0;
        aff_c     = 1'b0;
        aff_dc    = 1'b0;
        aff_z     = 1'b0;
        c_new     = sum[`PIC_DATA_W];
        test_zero = 1'b0;
        skip      = 1'b0;

        case (op_in.op)
            `PIC_OP_ADDWF, `PIC_OP_SUBWF: begin
                result    = sum[`PIC_DATA_W-1:0];
                byte_dest = 1'b1;
                aff_c     = 1'b1;
                aff_dc    = 1'b1;
                aff_z     = 1'b1;
            end
            `PIC_OP_ADDLW, `PIC_OP_SUBLW: begin
                result = sum[`PIC_DATA_W-1:0];
                to_w   = 1'b1;
                aff_c  = 1'b1;
                aff_dc = 1'b1;
                aff_z  = 1'b1;
            end
            `PIC_OP_ANDWF, `PIC_OP_ANDLW: begin
                result    = w & opnd;
                byte_dest = !lit_op;
                to_w      = lit_op;
                aff_z     = 1'b1;
            end
            `PIC_OP_IORWF, `PIC_OP_IORLW: begin
                result    = w | opnd;
                byte_dest = !lit_op;
                to_w      = lit_op;
                aff_z     = 1'b1;
            end
            `PIC_OP_XORWF, `PIC_OP_XORLW: begin
                result    = w ^ opnd;
                byte_dest = !lit_op;
                to_w      = lit_op;
                aff_z     = 1'b1;
            end
            `PIC_OP_CLRF, `PIC_OP_CLRW: begin
                result = '0;
                to_f   = (op_in.op == `PIC_OP_CLRF);
                to_w   = (op_in.op == `PIC_OP_CLRW);
                aff_z  = 1'b1;
            end
            `PIC_OP_COMF: begin
                result    = ~f;
                byte_dest = 1'b1;
                aff_z     = 1'b1;
            end
            `PIC_OP_INCF, `PIC_OP_DECF: begin
                result    = (op_in.op == `PIC_OP_INCF) ? f + ONE : f - ONE;
                byte_dest = 1'b1;
                aff_z     = 1'b1;
            end
            `PIC_OP_INCFSZ, `PIC_OP_DECFSZ: begin
                result    = (op_in.op == `PIC_OP_INCFSZ) ? f + ONE : f - ONE;
                byte_dest = 1'b1;
                test_zero = 1'b1;               // No flags touched
            end
            `PIC_OP_MOVF: begin
                byte_dest = 1'b1;
                aff_z     = 1'b1;               // Z test on F itself
            end
            `PIC_OP_MOVWF: begin
                result = w;
                to_f   = 1'b1;
            end
            `PIC_OP_MOVLW: begin
                result = op_in.literal;
                to_w   = 1'b1;
            end
            `PIC_OP_RLF: begin
                result    = {f[`PIC_DATA_W-2:0], status[`STATUS_C]};
                c_new     = f[`PIC_DATA_W-1];
                byte_dest = 1'b1;
                aff_c     = 1'b1;
            end
            `PIC_OP_RRF: begin
                result    = {status[`STATUS_C], f[`PIC_DATA_W-1:1]};
                c_new     = f[0];
                byte_dest = 1'b1;
                aff_c     = 1'b1;
            end
            `PIC_OP_SWAPF: begin
                result    = {f[NIB_W-1:0], f[`PIC_DATA_W-1:NIB_W]};
                byte_dest = 1'b1;
            end
            `PIC_OP_BCF: begin
                result = f & ~bit_mask;
                to_f   = 1'b1;
            end
            `PIC_OP_BSF: begin
                result = f | bit_mask;
                to_f   = 1'b1;
            end
            `PIC_OP_BTFSC: skip = !sel_bit;     // F left alone
            `PIC_OP_BTFSS: skip = sel_bit;
            default: ;                          // NOP
        endcase

        res_zero = (result == '0);
        if (test_zero) begin
            skip = res_zero;
        end

        write_w = byte_dest ? !op_in.dest_f : to_w;
        write_f = byte_dest ? op_in.dest_f : to_f;

        status_next = status;
        if (aff_c) begin
            status_next[`STATUS_C] = c_new;
        end
        if (aff_dc) begin
            status_next[`STATUS_DC] = nib_sum[NIB_W];
        end
        if (aff_z) begin
            status_next[`STATUS_Z] = res_zero;
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_execute.sv
`default_nettype none

module alu_execute (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         dec_valid,
    output logic                        dec_ready,
    input  wire pic_alu_pkg::decoded_t  dec_data,
    output logic                        out_valid,
    input  wire                         out_ready,
    output pic_alu_pkg::alu_result_t    out_data
);

    pic_alu_pkg::data_t   w_q;
    pic_alu_pkg::data_t   f_q;
    pic_alu_pkg::status_t status_q;
    pic_alu_pkg::data_t   result;
    pic_alu_pkg::data_t   w_next;
    pic_alu_pkg::data_t   f_next;
    pic_alu_pkg::status_t status_next;
    logic                 write_w;
    logic                 write_f;
    logic                 skip;
    logic                 dec_fire;

    assign dec_ready = !out_valid || out_ready;    // State only moves with the record
    assign dec_fire  = dec_valid && dec_ready;

    alu_datapath alu_datapath_i (
        .op_in       (dec_data),
        .w           (w_q),
        .f           (f_q),
        .status      (status_q),
        .result      (result),
        .write_w     (write_w),
        .write_f     (write_f),
        .status_next (status_next),
        .skip        (skip)
    );

    assign w_next = write_w ? result : w_q;
    assign f_next = write_f ? result : f_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_q       <= '0;
            f_q       <= '0;
            status_q  <= '0;
            out_valid <= 1'b0;
        end else if (dec_fire) begin
            w_q       <= w_next;
            f_q       <= f_next;
            status_q  <= status_next;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Record of the state right after the instruction
    always_ff @(posedge clk) begin
        if (dec_fire) begin
            out_data.w      <= w_next;
            out_data.f      <= f_next;
            out_data.status <= status_next;
            out_data.skip   <= skip;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pic_alu_top.sv
`default_nettype none

module pic_alu_top (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          in_valid,
    output wire                          in_ready,
    input  wire pic_alu_pkg::instr_t     in_data,
    output wire                          out_valid,
    input  wire                          out_ready,
    output wire pic_alu_pkg::alu_result_t out_data
);

    wire                        dec_valid;
    wire                        dec_ready;
    wire pic_alu_pkg::decoded_t dec_data;

    instr_decoder instr_decoder_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_data  (dec_data)
    );

    alu_execute alu_execute_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_data  (dec_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: test/pic_alu_properties.sv
`default_nettype none

module pic_alu_properties (
    input wire                           clk,
    input wire                           arst_n,
    input wire                           in_valid,
    input wire                           in_ready,
    input wire pic_alu_pkg::instr_t      in_data,
    input wire                           out_valid,
    input wire                           out_ready,
    input wire pic_alu_pkg::alu_result_t out_data
);

    int in_count;
    int out_count;
    int fails = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_count  <= 0;
            out_count <= 0;
        end else begin
            if (in_valid && in_ready) begin
                in_count <= in_count + 1;
            end
            if (out_valid && out_ready) begin
                out_count <= out_count + 1;
            end
        end
    end

    in_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else begin
            fails++;
            $error("input word dropped or changed before its transfer");
        end

    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fails++;
            $error("output record dropped or changed before its transfer");
        end

    out_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !out_valid)
        else begin
            fails++;
            $error("out_valid high in the cycle after reset");
        end

    no_extra_out: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> out_count < in_count)
        else begin
            fails++;
            $error("output transfer without a matching input transfer");
        end

endmodule

`default_nettype wire

// File: test/alu_checker.sv
`default_nettype none

module alu_checker (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           in_valid,
    input  wire                           in_ready,
    input  wire pic_alu_pkg::instr_t      in_data,
    input  wire                           out_valid,
    input  wire                           out_ready,
    input  wire pic_alu_pkg::alu_result_t out_data,
    output int                            errors,
    output int                            checks,
    output int                            pending
);

    pic_alu_pkg::data_t       m_w;
    pic_alu_pkg::data_t       m_f;
    logic                     m_c;
    logic                     m_dc;
    logic                     m_z;
    pic_alu_pkg::alu_result_t expected[$];
    pic_alu_pkg::alu_result_t exp_rec;
    int                       in_cycles[$];   // Edge number of each input transfer
    int                       cycle;
    int                       last_stall;
    int                       latency;

    initial begin
        errors  = 0;
        checks  = 0;
        pending = 0;
    end

    // Executes one word on the model and queues the record it should give
    task automatic model_step(input pic_alu_pkg::instr_t ins);
        pic_alu_pkg::data_t k;
        pic_alu_pkg::data_t r;
        logic               d;
        logic [2:0]         b;
        logic               byte_op;
        logic               z_upd;
        logic               wr_w;
        logic               wr_f;
        logic               skip;

        k       = ins[7:0];
        d       = ins[7];
        b       = ins[9:7];
        r       = m_f;
        byte_op = 1'b0;
        z_upd   = 1'b0;
        wr_w    = 1'b0;
        wr_f    = 1'b0;
        skip    = 1'b0;
        casez (ins[13:8])
            6'b000000: begin   // MOVWF when d is set, else NOP
                r    = m_w;
                wr_f = d;
            end
            6'b000001: begin   // CLRF or CLRW
                r       = '0;
                byte_op = 1'b1;
                z_upd   = 1'b1;
            end
            6'b000010: begin
                r       = m_f - m_w;
                m_c     = m_f >= m_w;                // No borrow
                m_dc    = m_f[3:0] >= m_w[3:0];
                byte_op = 1'b1;
                z_upd   = 1'b1;
            end
            6'b000111: begin
                {m_c, r} = m_f + m_w;
                m_dc     = (m_f[3:0] + m_w[3:0]) > 15;
                byte_op  = 1'b1;
                z_upd    = 1'b1;
            end
            6'b000011, 6'b000100, 6'b000101, 6'b000110, 6'b001000, 6'b001001,
            6'b001010: begin
                case (ins[11:8])
                    4'b0011: r = m_f - 8'd1;
                    4'b0100: r = m_w | m_f;
                    4'b0101: r = m_w & m_f;
                    4'b0110: r = m_w ^ m_f;
                    4'b1000: r = m_f;
                    4'b1001: r = ~m_f;
                    default: r = m_f + 8'd1;
                endcase
                byte_op = 1'b1;
                z_upd   = 1'b1;
            end
            6'b001011, 6'b001111: begin   // DECFSZ, INCFSZ
                r       = ins[10] ? m_f + 8'd1 : m_f - 8'd1;
                skip    = (r == 0);
                byte_op = 1'b1;
            end
            6'b001100: begin
                r       = {m_c, m_f[7:1]};
                m_c     = m_f[0];
                byte_op = 1'b1;
            end
            6'b001101: begin
                r       = {m_f[6:0], m_c};
                m_c     = m_f[7];
                byte_op = 1'b1;
            end
            6'b001110: begin
                r       = {m_f[3:0], m_f[7:4]};
                byte_op = 1'b1;
            end
            6'b0100??: begin
                r[b] = 1'b0;
                wr_f = 1'b1;
            end
            6'b0101??: begin
                r[b] = 1'b1;
                wr_f = 1'b1;
            end
            6'b0110??: skip = !m_f[b];
            6'b0111??: skip = m_f[b];
            6'b1100??: begin
                r    = k;
                wr_w = 1'b1;
            end
            6'b111000, 6'b111001, 6'b111010: begin
                r     = ins[9] ? m_w ^ k : (ins[8] ? m_w & k : m_w | k);
                wr_w  = 1'b1;
                z_upd = 1'b1;
            end
            6'b11110?: begin
                r     = k - m_w;
                m_c   = k >= m_w;
                m_dc  = k[3:0] >= m_w[3:0];
                wr_w  = 1'b1;
                z_upd = 1'b1;
            end
            6'b11111?: begin
                {m_c, r} = k + m_w;
                m_dc     = (k[3:0] + m_w[3:0]) > 15;
                wr_w     = 1'b1;
                z_upd    = 1'b1;
            end
            default: ;   // Unknown word acts as NOP
        endcase
        if (byte_op) begin
            wr_w = !d;
            wr_f = d;
        end
        if (z_upd) begin
            m_z = (r == 0);
        end
        if (wr_w) begin
            m_w = r;
        end
        if (wr_f) begin
            m_f = r;
        end
        expected.push_back({m_w, m_f, {m_z, m_dc, m_c}, skip});
    endtask

    task automatic compare_field(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_w  = '0;
            m_f  = '0;
            m_c  = 1'b0;
            m_dc = 1'b0;
            m_z  = 1'b0;
            expected.delete();
            in_cycles.delete();
            cycle      = 0;
            last_stall = 0;
            pending    = 0;
        end else begin
            cycle++;
            if (!out_ready) begin
                last_stall = cycle;
            end
            // First edge out of reset still has in_ready low
            if (cycle > 1 && out_ready && !in_ready) begin
                errors++;
                $display("error at %0t: in_ready low while out_ready was high", $time);
            end
            if (out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    errors++;
                    $display("error at %0t: a record came out with no instruction pending", $time);
                end else begin
                    exp_rec = expected.pop_front();
                    latency = cycle - in_cycles.pop_front();
                    compare_field("out_data.w", exp_rec.w, out_data.w);
                    compare_field("out_data.f", exp_rec.f, out_data.f);
                    compare_field("out_data.status", 8'(exp_rec.status), 8'(out_data.status));
                    compare_field("out_data.skip", 8'(exp_rec.skip), 8'(out_data.skip));
                    // Two edges from input to output unless out_ready dropped between
                    if (last_stall <= cycle - latency) begin
                        checks++;
                        if (latency != 2) begin
                            errors++;
                            $display("error at %0t: record latency %0d cycles instead of 2",
                                     $time, latency);
                        end
                    end
                end
            end
            if (in_valid && in_ready) begin
                model_step(in_data);
                in_cycles.push_back(cycle);
            end
            pending = expected.size();
        end
    end

endmodule

`default_nettype wire

// File: test/pic_alu_tb.sv
`default_nettype none

module pic_alu_tb;

    localparam int N_ARITH = 400;
    localparam int N_LOGIC = 400;
    localparam int N_BITS  = 400;
    localparam int N_BP    = 400;
    localparam int N_RST   = 20;
    localparam int TOTAL   = N_ARITH + N_LOGIC + N_BITS + N_BP + N_RST;
    localparam int LIMIT   = TOTAL * 8 * 6 + 2000;

    // Opcode bits 13..8, six bits per entry
    localparam logic [35:0] ARITH_OPS = {6'b000111, 6'b000010, 6'b111110, 6'b111100,
                                         6'b001010, 6'b000011};
    localparam logic [83:0] LOGIC_OPS = {6'b000101, 6'b000100, 6'b000110, 6'b111000,
                                         6'b111001, 6'b111010, 6'b001001, 6'b001000,
                                         6'b000000, 6'b110000, 6'b000001, 6'b001110,
                                         6'b001101, 6'b001100};
    localparam logic [47:0] BIT_OPS   = {6'b010000, 6'b011000, 6'b001111, 6'b001011,
                                         6'b100000, 6'b000000, 6'b110000, 6'b000001};

    logic                     clk = 1'b0;
    logic                     arst_n = 1'b0;
    logic                     in_valid = 1'b0;
    logic                     in_ready;
    pic_alu_pkg::instr_t      in_data = '0;
    logic                     out_valid;
    logic                     out_ready = 1'b0;
    pic_alu_pkg::alu_result_t out_data;
    logic                     stalls = 1'b0;
    logic                     took = 1'b0;
    int                       errors;
    int                       checks;
    int                       pending;
    int                       seed;

    pic_alu_top pic_alu_top_i (.*);

    alu_checker alu_checker_i (.*);

    bind pic_alu_top pic_alu_properties pic_alu_properties_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) took <= in_valid && in_ready;

    always @(negedge clk) out_ready = stalls ? 1'($urandom_range(0, 1)) : 1'b1;

    function automatic pic_alu_pkg::instr_t gen_word(input int kind);
        logic [5:0]          top;
        pic_alu_pkg::instr_t word;

        word = pic_alu_pkg::instr_t'($urandom);
        case (kind)
            0:       top = ARITH_OPS[6 * $urandom_range(0, 5) +: 6];
            1:       top = LOGIC_OPS[6 * $urandom_range(0, 13) +: 6];
            2:       top = BIT_OPS[6 * $urandom_range(0, 7) +: 6];
            default: top = word[13:8];   // Any word at all
        endcase
        if (kind == 2 && (top[5:4] == 2'b01 || top[5:4] == 2'b10)) begin
            word[13:12] = top[5:4];      // Keep bits 11..8 random
        end else begin
            word[13:8] = top;
        end
        if (kind == 1 && top == 6'b000000) begin
            word[7] = 1'b1;              // MOVWF rather than NOP
        end
        return word;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input pic_alu_pkg::instr_t word);
        in_valid = 1'b1;
        in_data  = word;
        @(negedge clk);
        while (!took) begin
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int kind, input int count);
        int errs_before;
        int checks_before;

        errs_before   = errors;
        checks_before = checks;
        for (int i = 0; i < count; i++) begin
            send(gen_word(kind));
        end
        while (pending != 0) begin
            @(negedge clk);
        end
        $display("test %s: %0d instructions, %0d checks, %0d errors", name, count,
                 checks - checks_before, errors - errs_before);
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
    endtask

    initial begin
        seed = $urandom(32'hdbef);
        apply_reset();
        run_test("arith_flags", 0, N_ARITH);
        run_test("logic_moves", 1, N_LOGIC);
        run_test("bit_ops_skips", 2, N_BITS);
        stalls = 1'b1;
        run_test("back_pressure", 3, N_BP);
        stalls = 1'b0;
        @(negedge clk);
        apply_reset();
        run_test("reset_restart", 3, N_RST);
        $display("totals: %0d checks, %0d errors, %0d records missing, %0d assertion failures",
                 checks, errors, pending, pic_alu_top_i.pic_alu_properties_i.fails);
        if (errors == 0 && pending == 0 && pic_alu_top_i.pic_alu_properties_i.fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(LIMIT);
        $display("Timeout after %0d time units with %0d records still missing", LIMIT, pending);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/pic_alu_pkg.sv
rtl/instr_decoder.sv
rtl/alu_datapath.sv
rtl/alu_execute.sv
rtl/pic_alu_top.sv
test/pic_alu_properties.sv
test/alu_checker.sv
test/pic_alu_tb.sv

// File: Bender.yml
package:
  name: pic_alu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pic_alu_pkg.sv
      - rtl/instr_decoder.sv
      - rtl/alu_datapath.sv
      - rtl/alu_execute.sv
      - rtl/pic_alu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/pic_alu_properties.sv
      - test/alu_checker.sv
      - test/pic_alu_tb.sv
